/* Makefile */
# Verilator build and run for the sample stream conditioner

VERILATOR ?= verilator
TOP       ?= tb_sample_stream
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
JOBS      ?= 4

SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/apb_cfg_regs.sv */
// APB configuration slave
// holds bypass, drop period, gain and shift; returns statistics on reads
`timescale 1ns/100ps
`default_nettype none

`include "stream_consts.svh"

module apb_cfg_regs (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [`STREAM_APB_AW-1:0] paddr,
  input  wire logic [31:0]               pwdata,
  input  wire stream_pkg::stream_stat_t  stats,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  output stream_pkg::stream_cfg_t        cfg,
  output logic                           stat_clear
);

  import stream_pkg::*;

  reg_sel_e    sel;
  logic        setup_phase;
  logic        access_wr;
  logic        addr_err;
  logic [31:0] rd_val;

  assign pready = 1'b1;  // no wait states

  // ====================
  // address decode
  always_comb begin
    case (paddr)
      `REG_CTRL_ADDR:    sel = SEL_CTRL;
      `REG_DROP_ADDR:    sel = SEL_DROP;
      `REG_GAIN_ADDR:    sel = SEL_GAIN;
      `REG_SENT_ADDR:    sel = SEL_SENT;
      `REG_DROPPED_ADDR: sel = SEL_DROPPED;
      default:           sel = SEL_NONE;
    endcase
  end

  assign setup_phase = psel & ~penable;
  assign access_wr   = psel & penable & pwrite;

  // unmapped, or write to a counter
  assign addr_err = (sel == SEL_NONE) |
                    (pwrite & ((sel == SEL_SENT) | (sel == SEL_DROPPED)));

  // read mux
  always_comb begin
    rd_val = '0;
    case (sel)
      SEL_CTRL:    rd_val[0] = cfg.bypass;  // clear bit reads back 0
      SEL_DROP:    rd_val[`STREAM_CNT_W-1:0] = cfg.drop_cycles;
      SEL_GAIN:    rd_val[`STREAM_GAIN_W+`STREAM_SHIFT_W-1:0] = {cfg.shift, cfg.gain};
      SEL_SENT:    rd_val[`STREAM_STAT_W-1:0] = stats.sent_count;
      SEL_DROPPED: rd_val[`STREAM_STAT_W-1:0] = stats.dropped_count;
      default:     rd_val = '0;
    endcase
  end

  // ====================
  // response, captured in setup so it is stable through access
  always_ff @(posedge clk) begin
    if (reset) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else if (setup_phase) begin
      prdata  <= pwrite ? '0 : rd_val;
      pslverr <= addr_err;
    end else begin
      pslverr <= 1'b0;  // drop error once access completes
    end
  end

  // ====================
  // control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.bypass      <= 1'b0;
      cfg.drop_cycles <= '0;
      cfg.gain        <= `REG_GAIN_RESET;
      cfg.shift       <= '0;
      stat_clear      <= 1'b0;
    end else begin
      stat_clear <= 1'b0;  // single cycle pulse
      if (access_wr) begin
        case (sel)
          SEL_CTRL: begin
            cfg.bypass <= pwdata[0];
            stat_clear <= pwdata[1];
          end
          SEL_DROP: begin
            cfg.drop_cycles <= pwdata[`STREAM_CNT_W-1:0];
          end
          SEL_GAIN: begin
            cfg.gain  <= pwdata[`STREAM_GAIN_W-1:0];
            cfg.shift <= pwdata[`STREAM_GAIN_W +: `STREAM_SHIFT_W];
          end
          default: begin
            // counters and unmapped addresses ignore writes
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/drop_unit.sv */
// decimating drop unit
// passes one accepted sample, then swallows input for a programmed period
`timescale 1ns/100ps
`default_nettype none

`include "stream_consts.svh"

module drop_unit (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire stream_pkg::stream_cfg_t cfg,
  input  wire stream_pkg::sample_t     in_data,
  input  wire logic                    in_val,
  output logic                         in_rdy,
  output stream_pkg::sample_t          mid_data,
  output logic                         mid_val,
  input  wire logic                    mid_rdy,
  output logic                         sent_evt,
  output logic                         dropped_evt
);

  import stream_pkg::*;

  localparam int CNT_W = `STREAM_CNT_W;

  drop_state_e      state;
  drop_state_e      next_state;
  logic [CNT_W-1:0] counter;     // cycles spent in DROP
  logic [CNT_W-1:0] period;      // drop_cycles latched while in SEND
  logic [CNT_W-1:0] last_count;
  logic             in_xfer;
  logic             decimate;

  assign in_xfer    = in_val & in_rdy;
  assign last_count = period - CNT_W'(2);  // DROP lasts period-1 cycles

  // periods of 0 or 1 pass everything
  assign decimate = ~cfg.bypass & (cfg.drop_cycles >= CNT_W'(2));

  // ====================
  // next state
  always_comb begin
    next_state = state;
    case (state)
      SEND: begin
        if (in_xfer && decimate) next_state = DROP;
      end
      DROP: begin
        if (counter == last_count || cfg.bypass) next_state = SEND;
      end
      default: next_state = SEND;
    endcase
  end

  // ====================
  // stream path
  always_comb begin
    if (state == SEND) begin
      in_rdy   = mid_rdy;  // straight through
      mid_data = in_data;
      mid_val  = in_val;
    end else begin
      in_rdy   = 1'b1;     // swallow everything
      mid_data = '0;
      mid_val  = 1'b0;
    end
  end

  assign sent_evt    = mid_val & mid_rdy;
  assign dropped_evt = (state == DROP) & in_val;

  // ====================
  // state, counter and period
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= SEND;
      counter <= '0;
      period  <= '0;
    end else begin
      state <= next_state;
      if (state == SEND) begin
        counter <= '0;
        period  <= cfg.drop_cycles;
      end else begin
        counter <= counter + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/sample_scaler.sv */
// gain stage
// sample * gain, arithmetic shift right, saturate, one register with val/rdy
`timescale 1ns/100ps
`default_nettype none

`include "stream_consts.svh"

module sample_scaler (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire stream_pkg::stream_cfg_t cfg,
  input  wire stream_pkg::sample_t     mid_data,
  input  wire logic                    mid_val,
  output logic                         mid_rdy,
  output stream_pkg::sample_t          out_data,
  output logic                         out_val,
  input  wire logic                    out_rdy
);

  localparam int DATA_W = `STREAM_DATA_W;
  localparam int PROD_W = `STREAM_DATA_W + `STREAM_GAIN_W + 1;

  logic signed [PROD_W-1:0]      product;
  logic signed [PROD_W-1:0]      shifted;
  logic        [PROD_W-DATA_W:0] upper;    // bits that must match the sign
  logic        [DATA_W-1:0]      scaled;
  logic                          load;

  // ====================
  // arithmetic
  assign product = mid_data * $signed({1'b0, cfg.gain});  // gain is unsigned
  assign shifted = product >>> cfg.shift;
  assign upper   = shifted[PROD_W-1:DATA_W-1];

  always_comb begin
    if (upper == '0 || upper == '1) begin
      scaled = shifted[DATA_W-1:0];  // fits
    end else if (shifted[PROD_W-1]) begin
      scaled = {1'b1, {(DATA_W-1){1'b0}}};  // clamp negative
    end else begin
      scaled = {1'b0, {(DATA_W-1){1'b1}}};  // clamp positive
    end
  end

  // ====================
  // output register
  assign mid_rdy = ~out_val | out_rdy;
  assign load    = mid_val & mid_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_val <= 1'b0;
    end else if (load) begin
      out_val <= 1'b1;
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  // payload, held while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= scaled;
    end
  end

endmodule

`default_nettype wire

/* hdl/sample_stream_top.sv */
// sample stream conditioner top
// APB config, drop unit, gain stage and statistics
`timescale 1ns/100ps
`default_nettype none

`include "stream_consts.svh"

module sample_stream_top (
  input  wire logic                      clk,
  input  wire logic                      reset,
  // APB
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [`STREAM_APB_AW-1:0] paddr,
  input  wire logic [31:0]               pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  // sample in
  input  wire logic [`STREAM_DATA_W-1:0] in_data,
  input  wire logic                      in_val,
  output logic                           in_rdy,
  // sample out
  output logic [`STREAM_DATA_W-1:0]      out_data,
  output logic                           out_val,
  input  wire logic                      out_rdy
);

  import stream_pkg::*;

  stream_cfg_t  cfg;
  stream_stat_t stats;
  sample_t      mid_data;
  logic         mid_val;
  logic         mid_rdy;
  logic         stat_clear;
  logic         sent_evt;
  logic         dropped_evt;

  apb_cfg_regs u_regs (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .stats(stats),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .cfg(cfg), .stat_clear(stat_clear)
  );

  drop_unit u_drop (
    .clk(clk), .reset(reset), .cfg(cfg),
    .in_data(in_data), .in_val(in_val), .in_rdy(in_rdy),
    .mid_data(mid_data), .mid_val(mid_val), .mid_rdy(mid_rdy),
    .sent_evt(sent_evt), .dropped_evt(dropped_evt)
  );

  sample_scaler u_scale (
    .clk(clk), .reset(reset), .cfg(cfg),
    .mid_data(mid_data), .mid_val(mid_val), .mid_rdy(mid_rdy),
    .out_data(out_data), .out_val(out_val), .out_rdy(out_rdy)
  );

  stream_stats u_stats (
    .clk(clk), .reset(reset),
    .sent_evt(sent_evt), .dropped_evt(dropped_evt),
    .stat_clear(stat_clear), .stats(stats)
  );

endmodule

`default_nettype wire

/* hdl/stream_consts.svh */
// stream conditioner constants
// widths, APB register map and reset values
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// ====================
// widths
`define STREAM_DATA_W    16
`define STREAM_CNT_W     5     // max drop period 31
`define STREAM_GAIN_W    8
`define STREAM_SHIFT_W   3
`define STREAM_STAT_W    16
`define STREAM_APB_AW    8

// ====================
// register map
`define REG_CTRL_ADDR    8'h00  // bit0 bypass, bit1 stats clear
`define REG_DROP_ADDR    8'h04
`define REG_GAIN_ADDR    8'h08  // gain 7:0, shift 10:8
`define REG_SENT_ADDR    8'h0C  // read only
`define REG_DROPPED_ADDR 8'h10  // read only

`define REG_GAIN_RESET   8'd1

`endif

/* hdl/stream_pkg.sv */
// stream conditioner types
// sample, config and statistics bundles plus state and register enums
`default_nettype none

`include "stream_consts.svh"

package stream_pkg;

  typedef logic signed [`STREAM_DATA_W-1:0] sample_t;

  // control fields written over APB
  typedef struct packed {
    logic                       bypass;
    logic [`STREAM_CNT_W-1:0]   drop_cycles;
    logic [`STREAM_GAIN_W-1:0]  gain;
    logic [`STREAM_SHIFT_W-1:0] shift;
  } stream_cfg_t;

  typedef struct packed {
    logic [`STREAM_STAT_W-1:0] sent_count;
    logic [`STREAM_STAT_W-1:0] dropped_count;
  } stream_stat_t;

  typedef enum logic {
    SEND,
    DROP
  } drop_state_e;

  // decoded APB target
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_CTRL,
    SEL_DROP,
    SEL_GAIN,
    SEL_SENT,
    SEL_DROPPED
  } reg_sel_e;

endpackage

`default_nettype wire

/* hdl/stream_stats.sv */
// statistics counters
// saturating sent and dropped counts, cleared by a register write
`timescale 1ns/100ps
`default_nettype none

`include "stream_consts.svh"

module stream_stats (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                sent_evt,
  input  wire logic                dropped_evt,
  input  wire logic                stat_clear,
  output stream_pkg::stream_stat_t stats
);

  localparam int STAT_W = `STREAM_STAT_W;

  // stick at all ones
  function automatic logic [STAT_W-1:0] sat_inc(
    input logic [STAT_W-1:0] cnt,
    input logic              evt
  );
    logic [STAT_W-1:0] nxt;
    nxt = cnt;
    if (evt && cnt != '1) begin
      nxt = cnt + 1'b1;
    end
    return nxt;
  endfunction

  // ====================
  // counters, clear beats a same cycle event
  always_ff @(posedge clk) begin
    if (reset) begin
      stats.sent_count    <= '0;
      stats.dropped_count <= '0;
    end else if (stat_clear) begin
      stats.sent_count    <= '0;
      stats.dropped_count <= '0;
    end else begin
      stats.sent_count    <= sat_inc(stats.sent_count, sent_evt);
      stats.dropped_count <= sat_inc(stats.dropped_count, dropped_evt);
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/stream_pkg.sv
hdl/apb_cfg_regs.sv
hdl/drop_unit.sv
hdl/sample_scaler.sv
hdl/stream_stats.sv
hdl/sample_stream_top.sv
testbench/tb_sample_stream.sv

/* testbench/tb_sample_stream.sv */
// testbench for the sample stream conditioner
// APB register access, bypass and gain, decimation, back-pressure, stats clear
`timescale 1ns/100ps
`default_nettype none

`include "stream_consts.svh"

module tb_sample_stream;

  localparam int          CLK_HALF     = 4;
  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'h2fac_9f17;
  // about 250 samples at up to 3 cycles each plus 50 APB transfers fit well inside
  localparam int          TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [15:0] in_data;
  logic        in_val;
  logic        in_rdy;
  logic [15:0] out_data;
  logic        out_val;
  logic        out_rdy;

  logic [31:0] stim_state;
  logic [31:0] sink_state;
  logic        sink_random;    // out_rdy from the LCG when set
  logic        stalled;
  logic [15:0] stalled_data;
  int          cycles = 0;
  logic [15:0] in_q[$];        // samples to offer
  logic [15:0] exp_q[$];
  logic [15:0] out_q[$];       // collected by the monitor

  sample_stream_top DUT (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .in_data(in_data), .in_val(in_val), .in_rdy(in_rdy),
    .out_data(out_data), .out_val(out_val), .out_rdy(out_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ====================
  // helpers
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // gain, arithmetic shift right, clamp to signed 16 bit
  function automatic logic [15:0] scale(input logic [15:0] sample, input int gain,
                                        input int shift);
    int prod;
    prod = int'($signed(sample)) * gain;
    prod = prod >>> shift;
    if (prod > 32767) prod = 32767;
    else if (prod < -32768) prod = -32768;
    return 16'(prod);
  endfunction

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] t=%0t %s expected 0x%0h got 0x%0h",
                         $time, name, expected, actual));
    end
  endtask

  // ====================
  // APB
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);  // response is stable in the access phase
    check_eq("pready", pready, 1);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata, err);
    check_eq("pslverr", err, 0);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, 32'h0, data, err);
    check_eq("pslverr", err, 0);
  endtask

  task automatic check_reg(input string name, input logic [7:0] addr,
                           input logic [31:0] expected);
    logic [31:0] data;
    apb_read(addr, data);
    check_eq(name, data, expected);
  endtask

  // ====================
  // stream
  task automatic fill_random(input int count);
    repeat (count) begin
      stim_state = lcg_next(stim_state);
      in_q.push_back(stim_state[31:16]);
    end
  endtask

  task automatic send_samples();
    foreach (in_q[i]) begin
      @(posedge clk);
      #1;
      in_data = in_q[i];
      in_val  = 1'b1;
      do begin
        @(negedge clk);
      end while (in_rdy !== 1'b1);  // transfer at the next edge
    end
    @(posedge clk);
    #1;
    in_val = 1'b0;
  endtask

  task automatic check_outputs();
    while (out_q.size() < exp_q.size()) @(negedge clk);
    repeat (4) @(posedge clk);  // catch extra outputs
    check_eq("output count", out_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      check_eq($sformatf("out_data[%0d]", i), out_q[i], exp_q[i]);
    end
    out_q.delete();
  endtask

  // sink ready
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (sink_random) begin
        sink_state = lcg_next(sink_state);
        out_rdy    = sink_state[16];
      end else begin
        out_rdy = 1'b1;
      end
    end
  end

  // output monitor that also checks a stalled output holds
  always @(negedge clk) begin
    if (reset) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        check_eq("out_val held", out_val, 1);
        check_eq("out_data held", out_data, stalled_data);
      end
      if (out_val && out_rdy) out_q.push_back(out_data);
      stalled      = out_val & ~out_rdy;
      stalled_data = out_data;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run("timeout: the run did not finish within the cycle limit");
    end
  end

  // ====================
  // tests
  task automatic test_registers();
    logic [31:0] data;
    logic        err;
    check_reg("prdata CTRL", `REG_CTRL_ADDR, 0);
    check_reg("prdata DROP", `REG_DROP_ADDR, 0);
    check_reg("prdata GAIN", `REG_GAIN_ADDR, `REG_GAIN_RESET);
    check_reg("prdata SENT", `REG_SENT_ADDR, 0);
    check_reg("prdata DROPPED", `REG_DROPPED_ADDR, 0);
    apb_write(`REG_CTRL_ADDR, 32'h1);
    check_reg("prdata CTRL", `REG_CTRL_ADDR, 32'h1);
    apb_write(`REG_DROP_ADDR, 32'd19);
    check_reg("prdata DROP", `REG_DROP_ADDR, 32'd19);
    apb_write(`REG_GAIN_ADDR, 32'h5a7);  // shift 5, gain 0xa7
    check_reg("prdata GAIN", `REG_GAIN_ADDR, 32'h5a7);
    apb_transfer(1'b1, `REG_SENT_ADDR, 32'h1234, data, err);
    check_eq("pslverr SENT write", err, 1);
    apb_transfer(1'b0, 8'h20, 32'h0, data, err);
    check_eq("pslverr 0x20 read", err, 1);
    apb_transfer(1'b1, 8'h20, 32'h5, data, err);
    check_eq("pslverr 0x20 write", err, 1);
    check_reg("prdata SENT", `REG_SENT_ADDR, 0);
    apb_write(`REG_CTRL_ADDR, 32'h0);
    apb_write(`REG_DROP_ADDR, 32'h0);
    apb_write(`REG_GAIN_ADDR, 32'h1);
  endtask

  task automatic test_bypass_gain();
    apb_write(`REG_CTRL_ADDR, 32'h1);
    in_q.delete();
    exp_q.delete();
    fill_random(40);
    foreach (in_q[i]) exp_q.push_back(scale(in_q[i], 1, 0));
    send_samples();
    check_outputs();
    apb_write(`REG_GAIN_ADDR, (32'd2 << 8) | 32'd200);
    in_q.delete();
    exp_q.delete();
    in_q.push_back(16'h7fff);  // +32767
    in_q.push_back(16'h8001);  // -32767
    fill_random(20);
    foreach (in_q[i]) exp_q.push_back(scale(in_q[i], 200, 2));
    send_samples();
    check_outputs();
    apb_write(`REG_GAIN_ADDR, 32'h1);
  endtask

  // source offers a sample every cycle and the sink is always ready
  task automatic run_decimation(input int period, input int sent, input int dropped);
    apb_write(`REG_CTRL_ADDR, 32'h0);
    apb_write(`REG_DROP_ADDR, period);
    in_q.delete();
    exp_q.delete();
    fill_random(40);
    foreach (in_q[i]) begin
      if (period < 2 || i % period == 0) exp_q.push_back(in_q[i]);
    end
    send_samples();
    check_outputs();
    check_reg("prdata SENT", `REG_SENT_ADDR, sent);
    check_reg("prdata DROPPED", `REG_DROPPED_ADDR, dropped);
  endtask

  task automatic test_backpressure();
    apb_write(`REG_CTRL_ADDR, 32'h1);
    apb_write(`REG_GAIN_ADDR, (32'd1 << 8) | 32'd3);  // x3 then >>1
    sink_random = 1'b1;
    in_q.delete();
    exp_q.delete();
    fill_random(60);
    foreach (in_q[i]) exp_q.push_back(scale(in_q[i], 3, 1));
    send_samples();
    check_outputs();
    sink_random = 1'b0;
    apb_write(`REG_GAIN_ADDR, 32'h1);
  endtask

  // counts left over from earlier traffic are cleared and counting restarts
  task automatic test_stats_clear();
    apb_write(`REG_CTRL_ADDR, 32'h3);
    check_reg("prdata SENT", `REG_SENT_ADDR, 0);
    check_reg("prdata DROPPED", `REG_DROPPED_ADDR, 0);
    run_decimation(4, 10, 30);
  endtask

  initial begin
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    in_data     = '0;
    in_val      = 1'b0;
    out_rdy     = 1'b1;
    sink_random = 1'b0;
    stalled     = 1'b0;
    stim_state  = SEED;
    sink_state  = SEED;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    test_registers();
    test_bypass_gain();
    apb_write(`REG_CTRL_ADDR, 32'h2);  // clear counts from bypass traffic
    run_decimation(4, 10, 30);
    apb_write(`REG_CTRL_ADDR, 32'h2);
    run_decimation(1, 40, 0);
    test_backpressure();
    test_stats_clear();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
